// ==== all.f ====
+incdir+include
logic/rob_pkg.sv
logic/rob_tag_alloc.sv
logic/rob_entry_array.sv
logic/rob_retire.sv
logic/rob_top.sv
verification/rob_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rob_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	@grep -qx "TEST OK" $(SIM_LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== verification/rob_tb.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_tb;
    import rob_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int WAIT_LIMIT     = 50;

    logic     clk = 1'b0;
    logic     rst;
    logic     dispatch_valid;
    op_kind_t dispatch_kind;
    reg_idx_t dispatch_rd;
    logic     dispatch_pred_taken;
    logic     dispatch_ready;
    rob_tag_t dispatch_tag;
    logic     wb_valid;
    rob_tag_t wb_tag;
    xlen_t    wb_data;
    logic     wb_taken;
    addr_t    wb_target;
    logic     commit_valid;
    logic     commit_ready;
    reg_idx_t commit_rd;
    xlen_t    commit_data;
    rob_tag_t commit_tag;
    logic     store_valid;
    logic     store_ready;
    rob_tag_t store_tag;
    logic     flush;
    addr_t    redirect_pc;

    // expected entries, built from what was dispatched and written back
    reg_idx_t m_rd     [`ROB_DEPTH];
    xlen_t    m_data   [`ROB_DEPTH];
    addr_t    m_target [`ROB_DEPTH];
    rob_tag_t exp_order[$];
    rob_tag_t exp_tail;

    logic [31:0] lcg_state = 32'h1183;
    int          cycle_count = 0;
    int          errors = 0;
    int          errors_at_start;
    int          tests_passed = 0;
    int          tests_failed = 0;

    rob_top rob_top_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic reset_dut();
        rst                 = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_kind       = OP_ALU;
        dispatch_rd         = '0;
        dispatch_pred_taken = 1'b0;
        wb_valid            = 1'b0;
        wb_tag              = '0;
        wb_data             = '0;
        wb_taken            = 1'b0;
        wb_target           = '0;
        commit_ready        = 1'b0;
        store_ready         = 1'b0;
        exp_tail            = '0;
        exp_order.delete();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
        check_bit("commit_valid", commit_valid, 1'b0);
        check_bit("store_valid", store_valid, 1'b0);
        check_bit("flush", flush, 1'b0);
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        reset_dut();
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    // holds the request until the handshake edge, then drops valid
    task automatic dispatch_op(input op_kind_t kind, input reg_idx_t rd, input logic pred);
        int waited = 0;
        dispatch_valid      = 1'b1;
        dispatch_kind       = kind;
        dispatch_rd         = rd;
        dispatch_pred_taken = pred;
        while (dispatch_ready !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (dispatch_ready !== 1'b1) begin
            report_failure("dispatch_ready never rose for a waiting dispatch");
        end else begin
            check_tag("dispatch_tag", dispatch_tag, exp_tail);
            m_rd[exp_tail] = rd;
            exp_order.push_back(exp_tail);
            exp_tail = rob_tag_t'((int'(exp_tail) + 1) % `ROB_DEPTH);
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic writeback(input rob_tag_t tag, input xlen_t data,
                             input logic taken, input addr_t target);
        wb_valid      = 1'b1;
        wb_tag        = tag;
        wb_data       = data;
        wb_taken      = taken;
        wb_target     = target;
        m_data[tag]   = data;
        m_target[tag] = target;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic expect_commit();
        rob_tag_t tag;
        int       waited = 0;
        logic     held_ready;
        tag        = exp_order.pop_front();
        held_ready = commit_ready;
        while (commit_valid !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (commit_valid !== 1'b1) begin
            report_failure("commit_valid never rose for the expected head");
        end else begin
            check_tag("commit_tag", commit_tag, tag);
            check_reg("commit_rd", commit_rd, m_rd[tag]);
            check_data("commit_data", commit_data, m_data[tag]);
            check_bit("store_valid", store_valid, 1'b0);
            commit_ready = 1'b1;
            @(negedge clk);
            commit_ready = held_ready;
        end
    endtask

    task automatic expect_store();
        rob_tag_t tag;
        int       waited = 0;
        tag = exp_order.pop_front();
        while (store_valid !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (store_valid !== 1'b1) begin
            report_failure("store_valid never rose for the expected store");
        end else begin
            check_tag("store_tag", store_tag, tag);
            check_bit("commit_valid", commit_valid, 1'b0);
            store_ready = 1'b1;
            @(negedge clk);
            store_ready = 1'b0;
        end
    endtask

    task automatic in_order_commit();
        rob_tag_t    order[$];
        rob_tag_t    t;
        logic [31:0] r;
        int          j;
        begin_test();
        for (int i = 0; i < 8; i++) begin
            order.push_back(exp_tail);
            dispatch_op(OP_ALU, reg_idx_t'(next_random() >> 7), 1'b0);
        end
        // shuffled writeback order
        for (int i = 7; i > 0; i--) begin
            r = next_random();
            j = int'(r % (i + 1));
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        foreach (order[k])
            writeback(order[k], xlen_t'(next_random()), 1'b0, '0);
        repeat (8) expect_commit();
        check_bit("commit_valid", commit_valid, 1'b0);
        end_test("in_order_commit");
    endtask

    task automatic full_and_wrap();
        begin_test();
        repeat (`ROB_DEPTH) dispatch_op(OP_ALU, reg_idx_t'(next_random() >> 7), 1'b0);
        check_bit("dispatch_ready", dispatch_ready, 1'b0);
        for (int i = 0; i < `ROB_DEPTH; i++)
            writeback(exp_order[i], xlen_t'(next_random()), 1'b0, '0);
        commit_ready = 1'b1;
        repeat (`ROB_DEPTH) expect_commit();
        commit_ready = 1'b0;
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
        // tail has wrapped back to entry zero
        dispatch_op(OP_ALU, reg_idx_t'(1), 1'b0);
        end_test("full_and_wrap");
    endtask

    task automatic store_release();
        rob_tag_t tag;
        begin_test();
        tag = exp_tail;
        dispatch_op(OP_STORE, '0, 1'b0);
        writeback(tag, xlen_t'(next_random()), 1'b0, '0);
        // offered in the cycle right after the writeback edge
        check_bit("store_valid", store_valid, 1'b1);
        check_bit("commit_valid", commit_valid, 1'b0);
        repeat (3) begin
            @(negedge clk);
            check_bit("store_valid", store_valid, 1'b1);
            check_tag("store_tag", store_tag, tag);
        end
        expect_store();
        check_bit("store_valid", store_valid, 1'b0);
        end_test("store_release");
    endtask

    task automatic commit_backpressure();
        rob_tag_t tag;
        begin_test();
        tag = exp_tail;
        dispatch_op(OP_ALU, reg_idx_t'(next_random() >> 3), 1'b0);
        writeback(tag, xlen_t'(next_random()), 1'b0, '0);
        repeat (4) begin
            check_bit("commit_valid", commit_valid, 1'b1);
            check_tag("commit_tag", commit_tag, tag);
            check_reg("commit_rd", commit_rd, m_rd[tag]);
            check_data("commit_data", commit_data, m_data[tag]);
            @(negedge clk);
        end
        expect_commit();
        end_test("commit_backpressure");
    endtask

    task automatic predicted_branch();
        rob_tag_t tag;
        begin_test();
        tag = exp_tail;
        dispatch_op(OP_BRANCH, reg_idx_t'(next_random() >> 3), 1'b1);
        writeback(tag, xlen_t'(next_random()), 1'b1, addr_t'(next_random()));
        expect_commit();
        repeat (3) begin
            check_bit("flush", flush, 1'b0);
            @(negedge clk);
        end
        end_test("predicted_branch");
    endtask

    task automatic mispredict_flush();
        rob_tag_t tag;
        begin_test();
        tag = exp_tail;
        dispatch_op(OP_BRANCH, reg_idx_t'(next_random() >> 3), 1'b0);
        dispatch_op(OP_ALU, reg_idx_t'(next_random() >> 3), 1'b0);
        dispatch_op(OP_ALU, reg_idx_t'(next_random() >> 3), 1'b0);
        dispatch_op(OP_STORE, '0, 1'b0);
        // younger entries complete before the branch resolves
        for (int i = 3; i > 0; i--)
            writeback(exp_order[i], xlen_t'(next_random()), 1'b0, '0);
        writeback(tag, xlen_t'(next_random()), 1'b1, addr_t'(next_random()));
        commit_ready = 1'b1;
        store_ready  = 1'b1;
        expect_commit();
        check_bit("flush", flush, 1'b1);
        check_addr("redirect_pc", redirect_pc, m_target[tag]);
        check_bit("dispatch_ready", dispatch_ready, 1'b0);
        check_bit("commit_valid", commit_valid, 1'b0);
        check_bit("store_valid", store_valid, 1'b0);
        exp_tail = '0;
        exp_order.delete();
        repeat (4) begin
            @(negedge clk);
            check_bit("flush", flush, 1'b0);
            check_bit("commit_valid", commit_valid, 1'b0);
            check_bit("store_valid", store_valid, 1'b0);
        end
        commit_ready = 1'b0;
        store_ready  = 1'b0;
        dispatch_op(OP_ALU, reg_idx_t'(2), 1'b0);
        end_test("mispredict_flush");
    endtask

    initial begin
        in_order_commit();
        full_and_wrap();
        store_release();
        commit_backpressure();
        predicted_branch();
        mispredict_flush();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/rob_top.sv ====
`timescale 1ns/1ps

module rob_top (
    input  logic              clk,
    input  logic              rst,
    // dispatch
    input  logic              dispatch_valid,
    input  rob_pkg::op_kind_t dispatch_kind,
    input  rob_pkg::reg_idx_t dispatch_rd,
    input  logic              dispatch_pred_taken,
    output logic              dispatch_ready,
    output rob_pkg::rob_tag_t dispatch_tag,
    // execution writeback
    input  logic              wb_valid,
    input  rob_pkg::rob_tag_t wb_tag,
    input  rob_pkg::xlen_t    wb_data,
    input  logic              wb_taken,
    input  rob_pkg::addr_t    wb_target,
    // register commit
    output logic              commit_valid,
    input  logic              commit_ready,
    output rob_pkg::reg_idx_t commit_rd,
    output rob_pkg::xlen_t    commit_data,
    output rob_pkg::rob_tag_t commit_tag,
    // store release
    output logic              store_valid,
    input  logic              store_ready,
    output rob_pkg::rob_tag_t store_tag,
    // redirect
    output logic              flush,
    output rob_pkg::addr_t    redirect_pc
);
    import rob_pkg::*;

    logic     alloc_fire;
    logic     retire;
    rob_tag_t head_ptr;
    logic     head_busy;
    logic     head_done;
    op_kind_t head_kind;
    reg_idx_t head_rd;
    xlen_t    head_data;
    logic     head_pred_taken;
    logic     head_taken;
    addr_t    head_target;

    rob_tag_alloc rob_tag_alloc_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .retire         (retire),
        .flush          (flush),
        .dispatch_ready (dispatch_ready),
        .alloc_fire     (alloc_fire),
        .dispatch_tag   (dispatch_tag)
    );

    // entries are written at the tag handed out this cycle
    rob_entry_array rob_entry_array_i (
        .clk                 (clk),
        .rst                 (rst),
        .alloc_fire          (alloc_fire),
        .retire              (retire),
        .flush               (flush),
        .alloc_tag           (dispatch_tag),
        .head_ptr            (head_ptr),
        .dispatch_kind       (dispatch_kind),
        .dispatch_rd         (dispatch_rd),
        .dispatch_pred_taken (dispatch_pred_taken),
        .wb_valid            (wb_valid),
        .wb_tag              (wb_tag),
        .wb_data             (wb_data),
        .wb_taken            (wb_taken),
        .wb_target           (wb_target),
        .head_busy           (head_busy),
        .head_done           (head_done),
        .head_kind           (head_kind),
        .head_rd             (head_rd),
        .head_data           (head_data),
        .head_pred_taken     (head_pred_taken),
        .head_taken          (head_taken),
        .head_target         (head_target)
    );

    rob_retire rob_retire_i (
        .clk             (clk),
        .rst             (rst),
        .head_busy       (head_busy),
        .head_done       (head_done),
        .head_pred_taken (head_pred_taken),
        .head_taken      (head_taken),
        .head_kind       (head_kind),
        .head_rd         (head_rd),
        .head_data       (head_data),
        .head_target     (head_target),
        .commit_ready    (commit_ready),
        .store_ready     (store_ready),
        .head_ptr        (head_ptr),
        .commit_tag      (commit_tag),
        .commit_valid    (commit_valid),
        .store_valid     (store_valid),
        .retire          (retire),
        .flush           (flush),
        .commit_rd       (commit_rd),
        .commit_data     (commit_data),
        .store_tag       (store_tag),
        .redirect_pc     (redirect_pc)
    );

endmodule

// ==== logic/rob_retire.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_retire (
    input  logic              clk,
    input  logic              rst,
    input  logic              head_busy,
    input  logic              head_done,
    input  logic              head_pred_taken,
    input  logic              head_taken,
    input  rob_pkg::op_kind_t head_kind,
    input  rob_pkg::reg_idx_t head_rd,
    input  rob_pkg::xlen_t    head_data,
    input  rob_pkg::addr_t    head_target,
    input  logic              commit_ready,
    input  logic              store_ready,
    output rob_pkg::rob_tag_t head_ptr,
    output rob_pkg::rob_tag_t commit_tag,
    output logic              commit_valid,
    output logic              store_valid,
    output logic              retire,
    output logic              flush,
    output rob_pkg::reg_idx_t commit_rd,
    output rob_pkg::xlen_t    commit_data,
    output rob_pkg::rob_tag_t store_tag,
    output rob_pkg::addr_t    redirect_pc
);
    import rob_pkg::*;

    logic     head_ready;
    logic     is_store;
    logic     commit_fire;
    logic     store_fire;
    logic     mispredict;
    rob_tag_t head_next;

    // head is complete and nothing is being squashed
    assign head_ready = head_busy && head_done && !flush;
    assign is_store   = (head_kind == OP_STORE);

    assign commit_valid = head_ready && !is_store;
    assign store_valid  = head_ready && is_store;

    assign commit_rd   = head_rd;
    assign commit_data = head_data;
    assign commit_tag  = head_ptr;
    assign store_tag   = head_ptr;

    assign commit_fire = commit_valid && commit_ready;
    assign store_fire  = store_valid && store_ready;
    assign retire      = commit_fire || store_fire;

    // wrong-path detection only once the branch actually leaves
    assign mispredict = commit_fire && (head_kind == OP_BRANCH) &&
                        (head_pred_taken != head_taken);

    assign head_next = (head_ptr == rob_tag_t'(`ROB_DEPTH - 1)) ? '0 : head_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            flush    <= 1'b0;
        end else begin
            flush <= mispredict;
            if (flush) begin
                head_ptr <= '0;
            end else if (retire) begin
                head_ptr <= head_next;
            end
        end
    end

    // redirect target, sampled with the flush request
    always_ff @(posedge clk) begin
        if (mispredict) begin
            redirect_pc <= head_target;
        end
    end

    // a stalled offer keeps its port and its fields until it is taken
    a_commit_hold: assert property (
        @(posedge clk) disable iff (rst)
        (commit_valid && !commit_ready) |=>
            (commit_valid && $stable(commit_tag) &&
             $stable(commit_rd) && $stable(commit_data))
    ) else $error("commit offer changed while stalled");

    a_store_hold: assert property (
        @(posedge clk) disable iff (rst)
        (store_valid && !store_ready) |=> (store_valid && $stable(store_tag))
    ) else $error("store offer changed while stalled");

    // squashed entries must not surface once the wipe is over
    a_quiet_flush: assert property (
        @(posedge clk) disable iff (rst)
        flush |=> (!commit_valid && !store_valid)
    ) else $error("squashed entry offered after flush");

endmodule

// ==== logic/rob_entry_array.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_entry_array (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_fire,
    input  logic              retire,
    input  logic              flush,
    input  rob_pkg::rob_tag_t alloc_tag,
    input  rob_pkg::rob_tag_t head_ptr,
    input  rob_pkg::op_kind_t dispatch_kind,
    input  rob_pkg::reg_idx_t dispatch_rd,
    input  logic              dispatch_pred_taken,
    input  logic              wb_valid,
    input  rob_pkg::rob_tag_t wb_tag,
    input  rob_pkg::xlen_t    wb_data,
    input  logic              wb_taken,
    input  rob_pkg::addr_t    wb_target,
    output logic              head_busy,
    output logic              head_done,
    output rob_pkg::op_kind_t head_kind,
    output rob_pkg::reg_idx_t head_rd,
    output rob_pkg::xlen_t    head_data,
    output logic              head_pred_taken,
    output logic              head_taken,
    output rob_pkg::addr_t    head_target
);
    import rob_pkg::*;

    // per-entry state
    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] done;
    logic [`ROB_DEPTH-1:0] pred_q;
    logic [`ROB_DEPTH-1:0] taken_q;
    op_kind_t              kind_q   [`ROB_DEPTH];
    reg_idx_t              rd_q     [`ROB_DEPTH];
    xlen_t                 data_q   [`ROB_DEPTH];
    addr_t                 target_q [`ROB_DEPTH];

    logic wb_fire;

    // results landing in the flush cycle belong to squashed work
    assign wb_fire = wb_valid && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
            done <= '0;
        end else begin
            if (retire) begin
                busy[head_ptr] <= 1'b0;
                done[head_ptr] <= 1'b0;
            end
            if (alloc_fire) begin
                busy[alloc_tag] <= 1'b1;
                done[alloc_tag] <= 1'b0;
            end
            if (wb_fire) begin
                done[wb_tag] <= 1'b1;
            end
        end
    end

    // dispatch fields
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            kind_q[alloc_tag] <= dispatch_kind;
            rd_q[alloc_tag]   <= dispatch_rd;
            pred_q[alloc_tag] <= dispatch_pred_taken;
        end
    end

    // execution results
    always_ff @(posedge clk) begin
        if (wb_fire) begin
            data_q[wb_tag]   <= wb_data;
            taken_q[wb_tag]  <= wb_taken;
            target_q[wb_tag] <= wb_target;
        end
    end

    // head view for the retire logic
    assign head_busy       = busy[head_ptr];
    assign head_done       = done[head_ptr];
    assign head_kind       = kind_q[head_ptr];
    assign head_rd         = rd_q[head_ptr];
    assign head_data       = data_q[head_ptr];
    assign head_pred_taken = pred_q[head_ptr];
    assign head_taken      = taken_q[head_ptr];
    assign head_target     = target_q[head_ptr];

    // tag must come from a live dispatch that has not finished yet
    a_wb_live_entry: assert property (
        @(posedge clk) disable iff (rst)
        wb_fire |-> (busy[wb_tag] && !done[wb_tag])
    ) else $error("writeback to idle or already completed entry");

    // tail and head bookkeeping in the other blocks must keep this true
    a_alloc_free_entry: assert property (
        @(posedge clk) disable iff (rst)
        alloc_fire |-> !busy[alloc_tag]
    ) else $error("dispatch into an occupied entry");

endmodule

// ==== logic/rob_tag_alloc.sv ====
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_tag_alloc (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch_valid,
    input  logic              retire,
    input  logic              flush,
    output logic              dispatch_ready,
    output logic              alloc_fire,
    output rob_pkg::rob_tag_t dispatch_tag
);
    import rob_pkg::*;

    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    rob_tag_t         tail;
    logic [CNT_W-1:0] count;
    logic             full;

    assign full = (count == CNT_W'(`ROB_DEPTH));

    // no new entries while the buffer is being wiped
    assign dispatch_ready = !full && !flush;
    assign alloc_fire     = dispatch_valid && dispatch_ready;
    assign dispatch_tag   = tail;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_fire) begin
                if (tail == rob_tag_t'(`ROB_DEPTH - 1)) begin
                    tail <= '0;
                end else begin
                    tail <= tail + 1'b1;
                end
            end

            // dispatch and retire in the same cycle cancel out
            case ({alloc_fire, retire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= CNT_W'(`ROB_DEPTH)
    ) else $error("occupancy count above buffer depth");

    // retire comes from the head logic in another block
    a_no_retire_empty: assert property (
        @(posedge clk) disable iff (rst)
        retire |-> (count != '0)
    ) else $error("retire while buffer is empty");

endmodule

// ==== logic/rob_pkg.sv ====
`include "rob_defs.svh"

package rob_pkg;

    // entry index, doubles as the instruction tag
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // destination register
    typedef logic [`REG_W-1:0] reg_idx_t;

    // result value
    typedef logic [`XLEN-1:0] xlen_t;

    // branch target
    typedef logic [`XLEN-1:0] addr_t;

    // what the entry does at retire
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_STORE  = 2'd2
    } op_kind_t;

endpackage

// ==== include/rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// reorder buffer sizing
`define ROB_DEPTH 16

// tag indexes one entry, so 2**ROB_TAG_W must cover ROB_DEPTH
`define ROB_TAG_W 4

// datapath width for results and PCs
`define XLEN 32

// architectural register index
`define REG_W 5

`endif
